/* dv/lc4_tb.sv */
`timescale 1ns/1ps
`include "lc4_macros.svh"

module lc4_tb import lc4_pkg::*; ();

    localparam int RST_CYCLES = 4;
    localparam int MAX_STEPS  = 200;
    localparam int RAND_LEN   = 40;
    localparam int SEED       = 42134;

    // one retired instruction as the ISA sees it
    typedef struct packed {
        lc4_word_t  pc;
        lc4_word_t  insn;
        logic       regfile_we;
        lc4_rsel_t  wsel;
        lc4_word_t  wdata;
        logic       nzp_we;
        logic [2:0] nzp;
    } trace_rec_t;

    logic       gwe;
    logic       i_rst;
    lc4_word_t  o_imem_addr;
    lc4_word_t  i_imem_insn;
    lc4_word_t  o_dmem_addr;
    logic       o_dmem_we;
    lc4_word_t  o_dmem_wdata;
    lc4_word_t  i_dmem_rdata;
    logic       o_trace_valid;
    lc4_word_t  o_trace_pc;
    lc4_word_t  o_trace_insn;
    logic       o_regfile_we;
    lc4_rsel_t  o_regfile_wsel;
    lc4_word_t  o_regfile_wdata;
    logic       o_nzp_we;
    logic [2:0] o_nzp_bits;

    lc4_word_t  prog [0:255];
    lc4_word_t  rom [0:255];
    lc4_word_t  dram [0:255];
    lc4_word_t  imem_off;
    int         prog_len;
    logic       load_mem;

    // architectural state of the reference model
    lc4_word_t  model_pc;
    lc4_word_t  model_regs [0:`LC4_NREGS-1];
    logic [2:0] model_nzp;
    lc4_word_t  model_dram [0:255];

    trace_rec_t exp_q [$];
    logic       checking;
    int         rec_idx;
    int         cycle_budget;
    int         cycle_count;

    lc4_core DUT (
        .gwe             (gwe),
        .i_rst           (i_rst),
        .o_imem_addr     (o_imem_addr),
        .i_imem_insn     (i_imem_insn),
        .o_dmem_addr     (o_dmem_addr),
        .o_dmem_we       (o_dmem_we),
        .o_dmem_wdata    (o_dmem_wdata),
        .i_dmem_rdata    (i_dmem_rdata),
        .o_trace_valid   (o_trace_valid),
        .o_trace_pc      (o_trace_pc),
        .o_trace_insn    (o_trace_insn),
        .o_regfile_we    (o_regfile_we),
        .o_regfile_wsel  (o_regfile_wsel),
        .o_regfile_wdata (o_regfile_wdata),
        .o_nzp_we        (o_nzp_we),
        .o_nzp_bits      (o_nzp_bits)
    );

    initial begin
        gwe = 1'b0;
        forever #2 gwe = ~gwe;
    end

    function automatic lc4_word_t fill_word(logic [7:0] a);
        return {a ^ 8'ha5, a};
    endfunction

    function automatic lc4_word_t enc_const(lc4_rsel_t d, logic [8:0] imm);
        return {4'h9, d, imm};
    endfunction

    function automatic lc4_word_t enc_add(lc4_rsel_t d, lc4_rsel_t s, lc4_rsel_t t);
        return {4'h1, d, s, 3'b000, t};
    endfunction

    function automatic lc4_word_t enc_sub(lc4_rsel_t d, lc4_rsel_t s, lc4_rsel_t t);
        return {4'h1, d, s, 3'b010, t};
    endfunction

    function automatic lc4_word_t enc_addi(lc4_rsel_t d, lc4_rsel_t s, logic [4:0] imm);
        return {4'h1, d, s, 1'b1, imm};
    endfunction

    function automatic lc4_word_t enc_and(lc4_rsel_t d, lc4_rsel_t s, lc4_rsel_t t);
        return {4'h5, d, s, 3'b000, t};
    endfunction

    function automatic lc4_word_t enc_andi(lc4_rsel_t d, lc4_rsel_t s, logic [4:0] imm);
        return {4'h5, d, s, 1'b1, imm};
    endfunction

    function automatic lc4_word_t enc_ldr(lc4_rsel_t d, lc4_rsel_t s, logic [5:0] imm);
        return {4'h6, d, s, imm};
    endfunction

    function automatic lc4_word_t enc_str(lc4_rsel_t t, lc4_rsel_t s, logic [5:0] imm);
        return {4'h7, t, s, imm};
    endfunction

    function automatic lc4_word_t enc_br(logic [2:0] mask, logic [8:0] imm);
        return {4'h0, mask, imm};
    endfunction

    function automatic logic [2:0] nzp_of(lc4_word_t v);
        if (v[15]) begin
            return 3'b100;
        end else if (v == 16'h0000) begin
            return 3'b010;
        end
        return 3'b001;
    endfunction

    // executes the instruction at model_pc and updates the model state
    function automatic trace_rec_t lc4_ref_step();
        trace_rec_t rec;
        lc4_word_t  pc_off;
        lc4_word_t  insn;
        lc4_word_t  rs;
        lc4_word_t  rt;
        lc4_word_t  val;
        lc4_word_t  addr;
        lc4_word_t  next_pc;
        logic       we;
        pc_off  = model_pc - `LC4_RESET_PC;
        insn    = prog[pc_off[7:0]];
        rs      = model_regs[insn[8:6]];
        rt      = model_regs[insn[2:0]];
        next_pc = model_pc + 16'd1;
        val     = 16'h0000;
        we      = 1'b0;
        case (insn[15:12])
            4'h0: begin
                if ((insn[11:9] & model_nzp) != 3'b000) begin
                    next_pc = next_pc + {{7{insn[8]}}, insn[8:0]};
                end
            end
            4'h1: begin
                we = insn[5] || insn[5:3] == 3'b000 || insn[5:3] == 3'b010;
                if (insn[5]) begin
                    val = rs + {{11{insn[4]}}, insn[4:0]};
                end else if (insn[5:3] == 3'b010) begin
                    val = rs - rt;
                end else begin
                    val = rs + rt;
                end
            end
            4'h5: begin
                we  = insn[5] || insn[5:3] == 3'b000;
                val = insn[5] ? (rs & {{11{insn[4]}}, insn[4:0]}) : (rs & rt);
            end
            4'h6: begin
                addr = rs + {{10{insn[5]}}, insn[5:0]};
                val  = model_dram[addr[7:0]];
                we   = 1'b1;
            end
            4'h7: begin
                addr = rs + {{10{insn[5]}}, insn[5:0]};
                model_dram[addr[7:0]] = model_regs[insn[11:9]];
            end
            4'h9: begin
                val = {{7{insn[8]}}, insn[8:0]};
                we  = 1'b1;
            end
            default: begin
                we = 1'b0;
            end
        endcase
        rec.pc         = model_pc;
        rec.insn       = insn;
        rec.regfile_we = we;
        rec.wsel       = insn[11:9];
        rec.wdata      = val;
        rec.nzp_we     = we;
        rec.nzp        = nzp_of(val);
        if (we) begin
            model_regs[insn[11:9]] = val;
            model_nzp = rec.nzp;
        end
        model_pc = next_pc;
        return rec;
    endfunction

    task automatic clear_program();
        for (int a = 0; a < 256; a++) begin
            prog[a] = `LC4_NOP_INSN;
        end
        prog_len = 0;
    endtask

    task automatic append_insn(input lc4_word_t w);
        prog[prog_len] = w;
        prog_len++;
    endtask

    task automatic build_directed_program();
        clear_program();
        // dependent ALU chain for MX and WX paths
        append_insn(enc_const(3'd1, 9'd5));
        append_insn(enc_const(3'd2, -9'd3));
        append_insn(enc_add(3'd3, 3'd1, 3'd2));
        append_insn(enc_add(3'd4, 3'd3, 3'd3));
        append_insn(enc_sub(3'd2, 3'd4, 3'd1));
        append_insn(enc_and(3'd5, 3'd4, 3'd1));
        append_insn(enc_addi(3'd6, 3'd5, -5'd7));
        append_insn(enc_andi(3'd7, 3'd6, 5'd15));
        append_insn(enc_add(3'd1, 3'd7, 3'd6));
        // load followed by its consumer
        append_insn(enc_ldr(3'd2, 3'd0, 6'd10));
        append_insn(enc_add(3'd3, 3'd2, 3'd1));
        append_insn(enc_ldr(3'd4, 3'd0, 6'd11));
        append_insn(enc_addi(3'd5, 3'd4, 5'd1));
        // store data from the previous instruction and read it back
        append_insn(enc_addi(3'd6, 3'd3, 5'd2));
        append_insn(enc_str(3'd6, 3'd0, 6'd20));
        append_insn(enc_ldr(3'd7, 3'd0, 6'd20));
        append_insn(enc_str(3'd7, 3'd0, 6'd21));
        append_insn(enc_ldr(3'd1, 3'd0, 6'd21));
        // taken and not-taken branches whose skipped slots must not retire
        append_insn(enc_const(3'd2, 9'd0));
        append_insn(enc_br(3'b010, 9'd1));
        append_insn(enc_const(3'd3, 9'd99));
        append_insn(enc_br(3'b001, 9'd1));
        append_insn(enc_addi(3'd4, 3'd2, -5'd1));
        append_insn(enc_br(3'b100, 9'd2));
        append_insn(enc_const(3'd5, 9'd1));
        append_insn(enc_const(3'd5, 9'd2));
        // branch on NZP from a load in the memory stage
        append_insn(enc_ldr(3'd6, 3'd0, 6'd30));
        append_insn(enc_br(3'b100, 9'd1));
        append_insn(enc_const(3'd7, 9'd3));
        append_insn(enc_ldr(3'd6, 3'd0, 6'd31));
        append_insn(enc_br(3'b011, 9'd1));
        append_insn(enc_const(3'd7, 9'd4));
        append_insn(enc_const(3'd0, 9'd1));
        append_insn(enc_br(3'b111, 9'h1ff));
    endtask

    task automatic build_random_program();
        int        kind;
        int        max_off;
        lc4_rsel_t d;
        lc4_rsel_t s;
        lc4_rsel_t t;
        clear_program();
        for (int k = 0; k < RAND_LEN; k++) begin
            kind = $urandom_range(8, 0);
            d    = 3'($urandom_range(7, 0));
            s    = 3'($urandom_range(7, 0));
            t    = 3'($urandom_range(7, 0));
            case (kind)
                0: append_insn(enc_const(d, 9'($urandom)));
                1: append_insn(enc_add(d, s, t));
                2: append_insn(enc_addi(d, s, 5'($urandom)));
                3: append_insn(enc_and(d, s, t));
                4: append_insn(enc_andi(d, s, 5'($urandom)));
                5: append_insn(enc_ldr(d, s, 6'($urandom)));
                6: append_insn(enc_str(t, s, 6'($urandom)));
                7: append_insn(enc_sub(d, s, t));
                default: begin
                    // forward only and never past the closing CONST
                    max_off = RAND_LEN - 1 - k;
                    if (max_off > 4) begin
                        max_off = 4;
                    end
                    append_insn(enc_br(3'($urandom_range(7, 1)),
                                       9'($urandom_range(max_off, 0))));
                end
            endcase
        end
        append_insn(enc_const(3'd0, 9'd1));
        append_insn(enc_br(3'b111, 9'h1ff));
    endtask

    task automatic reset_model();
        model_pc  = `LC4_RESET_PC;
        model_nzp = 3'b000;
        for (int r = 0; r < `LC4_NREGS; r++) begin
            model_regs[r] = 16'h0000;
        end
        for (int a = 0; a < 256; a++) begin
            model_dram[a] = fill_word(8'(a));
        end
    endtask

    task automatic run_program(input string label);
        trace_rec_t rec;
        int         steps;
        bit         halted;
        i_rst    = 1'b1;
        load_mem = 1'b1;
        checking = 1'b0;
        reset_model();
        exp_q.delete();
        steps  = 0;
        halted = 1'b0;
        while (!halted && steps < MAX_STEPS) begin
            rec = lc4_ref_step();
            exp_q.push_back(rec);
            steps++;
            halted = (model_pc == rec.pc);
        end
        if (!halted) begin
            $display("reference model ran %0d steps without reaching the halt branch", steps);
            $display("** FAIL **");
            $fatal(1);
        end
        $display("running %s program with %0d retired instructions", label, steps);
        cycle_budget += 4 * steps + RST_CYCLES + 1;
        repeat (RST_CYCLES) @(negedge gwe);
        load_mem = 1'b0;
        i_rst    = 1'b0;
        checking = 1'b1;
        while (rec_idx < steps) begin
            @(negedge gwe);
        end
        checking = 1'b0;
        // every store the core issued must have landed at the model's address
        for (int a = 0; a < 256; a++) begin
            check_val($sformatf("dram word %0d", a), dram[a], model_dram[a]);
        end
    endtask

    task automatic check_val(input string name, input lc4_word_t got, input lc4_word_t exp);
        if (got !== exp) begin
            $display("Mismatch %s at record %0d: got %h, expected %h", name, rec_idx, got, exp);
            $display("** FAIL **");
            $fatal(1);
        end
    endtask

    // combinational memories answered on the falling edge
    initial begin
        i_imem_insn  = `LC4_NOP_INSN;
        i_dmem_rdata = 16'h0000;
        forever begin
            @(negedge gwe);
            if (load_mem) begin
                for (int a = 0; a < 256; a++) begin
                    rom[a]  = prog[a];
                    dram[a] = fill_word(8'(a));
                end
            end else if (o_dmem_we) begin
                dram[o_dmem_addr[7:0]] = o_dmem_wdata;
            end
            i_imem_insn  = rom[imem_off[7:0]];
            i_dmem_rdata = dram[o_dmem_addr[7:0]];
        end
    end

    assign imem_off = o_imem_addr - `LC4_RESET_PC;

    // trace pulses against model records in order
    always @(negedge gwe) begin
        if (!checking) begin
            rec_idx = 0;
        end else if (o_trace_valid && rec_idx < exp_q.size()) begin
            check_val("o_trace_pc", o_trace_pc, exp_q[rec_idx].pc);
            check_val("o_trace_insn", o_trace_insn, exp_q[rec_idx].insn);
            check_val("o_regfile_we", 16'(o_regfile_we), 16'(exp_q[rec_idx].regfile_we));
            if (exp_q[rec_idx].regfile_we) begin
                check_val("o_regfile_wsel", 16'(o_regfile_wsel), 16'(exp_q[rec_idx].wsel));
                check_val("o_regfile_wdata", o_regfile_wdata, exp_q[rec_idx].wdata);
            end
            check_val("o_nzp_we", 16'(o_nzp_we), 16'(exp_q[rec_idx].nzp_we));
            if (exp_q[rec_idx].nzp_we) begin
                check_val("o_nzp_bits", 16'(o_nzp_bits), 16'(exp_q[rec_idx].nzp));
            end
            rec_idx++;
        end
    end

    initial begin
        cycle_count = 0;
        forever begin
            @(posedge gwe);
            cycle_count++;
            if (cycle_count > cycle_budget) begin
                $display("watchdog expired after %0d cycles with %0d of %0d trace records seen",
                         cycle_count, rec_idx, exp_q.size());
                $display("** FAIL **");
                $fatal(1);
            end
        end
    end

    initial begin
        i_rst        = 1'b1;
        load_mem     = 1'b1;
        checking     = 1'b0;
        rec_idx      = 0;
        cycle_budget = 20;
        void'($urandom(SEED));
        build_directed_program();
        run_program("directed");
        for (int p = 0; p < 3; p++) begin
            build_random_program();
            run_program("random");
        end
        $display("** PASS **");
        $finish;
    end

endmodule

/* include/lc4_macros.svh */
`ifndef LC4_MACROS_SVH
`define LC4_MACROS_SVH

// datapath and address width
`define LC4_XLEN 16

// size of the register file
`define LC4_NREGS 8

// first fetch address out of reset
`define LC4_RESET_PC 16'h8200

// BR with an empty mask, never taken
`define LC4_NOP_INSN 16'h0000

`endif

/* logic/lc4_core.sv */
`timescale 1ns/1ps

module lc4_core import lc4_pkg::*; (
    input  logic       gwe,
    input  logic       i_rst,
    output lc4_word_t  o_imem_addr,
    input  lc4_word_t  i_imem_insn,
    output lc4_word_t  o_dmem_addr,
    output logic       o_dmem_we,
    output lc4_word_t  o_dmem_wdata,
    input  lc4_word_t  i_dmem_rdata,
    output logic       o_trace_valid,
    output lc4_word_t  o_trace_pc,
    output lc4_word_t  o_trace_insn,
    output logic       o_regfile_we,
    output lc4_rsel_t  o_regfile_wsel,
    output lc4_word_t  o_regfile_wdata,
    output logic       o_nzp_we,
    output logic [2:0] o_nzp_bits
);

    lc4_word_t d_pc;
    lc4_word_t d_insn;
    logic      d_valid;
    logic      stall;
    logic      flush;
    lc4_word_t target;
    lc4_rsel_t rs_sel;
    lc4_rsel_t rt_sel;
    lc4_word_t rs_data;
    lc4_word_t rt_data;
    lc4_ctrl_t x_ctrl;
    lc4_word_t x_pc;
    lc4_word_t x_insn;
    logic      x_valid;
    lc4_word_t x_result;
    lc4_word_t x_store_data;

    lc4_fwd_if fwd ();

    // register read fields; a store names its data register in insn[11:9]
    assign rs_sel = d_insn[8:6];
    assign rt_sel = (d_insn[15:12] == OP_STR) ? d_insn[11:9] : d_insn[2:0];

    lc4_fetch u_fetch (
        .gwe         (gwe),
        .i_rst       (i_rst),
        .i_stall     (stall),
        .i_flush     (flush),
        .i_target    (target),
        .o_imem_addr (o_imem_addr),
        .i_imem_insn (i_imem_insn),
        .o_d_pc      (d_pc),
        .o_d_insn    (d_insn),
        .o_d_valid   (d_valid)
    );

    lc4_regfile u_regfile (
        .gwe       (gwe),
        .i_rst     (i_rst),
        .i_rs_sel  (rs_sel),
        .i_rt_sel  (rt_sel),
        .o_rs_data (rs_data),
        .o_rt_data (rt_data),
        .i_we      (o_regfile_we),
        .i_wsel    (o_regfile_wsel),
        .i_wdata   (o_regfile_wdata)
    );

    lc4_execute u_execute (
        .gwe            (gwe),
        .i_rst          (i_rst),
        .i_d_pc         (d_pc),
        .i_d_insn       (d_insn),
        .i_d_valid      (d_valid),
        .i_rs_data      (rs_data),
        .i_rt_data      (rt_data),
        .fwd            (fwd.dst),
        .o_stall        (stall),
        .o_flush        (flush),
        .o_target       (target),
        .o_x_ctrl       (x_ctrl),
        .o_x_pc         (x_pc),
        .o_x_insn       (x_insn),
        .o_x_valid      (x_valid),
        .o_x_result     (x_result),
        .o_x_store_data (x_store_data)
    );

    lc4_memwb u_memwb (
        .gwe             (gwe),
        .i_rst           (i_rst),
        .i_x_ctrl        (x_ctrl),
        .i_x_pc          (x_pc),
        .i_x_insn        (x_insn),
        .i_x_valid       (x_valid),
        .i_x_result      (x_result),
        .i_x_store_data  (x_store_data),
        .o_dmem_addr     (o_dmem_addr),
        .o_dmem_we       (o_dmem_we),
        .o_dmem_wdata    (o_dmem_wdata),
        .i_dmem_rdata    (i_dmem_rdata),
        .fwd             (fwd.src),
        .o_trace_valid   (o_trace_valid),
        .o_trace_pc      (o_trace_pc),
        .o_trace_insn    (o_trace_insn),
        .o_regfile_we    (o_regfile_we),
        .o_regfile_wsel  (o_regfile_wsel),
        .o_regfile_wdata (o_regfile_wdata),
        .o_nzp_we        (o_nzp_we),
        .o_nzp_bits      (o_nzp_bits)
    );

endmodule

/* logic/lc4_decoder.sv */
`timescale 1ns/1ps

module lc4_decoder import lc4_pkg::*; (
    input  lc4_word_t i_insn,
    output lc4_ctrl_t o_ctrl
);

    lc4_opcode_e opcode;

    always_comb begin
        case (i_insn[15:12])
            4'h0:    opcode = OP_BR;
            4'h1:    opcode = OP_ARITH;
            4'h5:    opcode = OP_LOGIC;
            4'h6:    opcode = OP_LDR;
            4'h7:    opcode = OP_STR;
            4'h9:    opcode = OP_CONST;
            default: opcode = OP_OTHER;
        endcase
    end

    always_comb begin
        o_ctrl        = '0;
        o_ctrl.alu_op = ALU_NONE;
        o_ctrl.rd_sel = i_insn[11:9];
        o_ctrl.rs_sel = i_insn[8:6];
        o_ctrl.rt_sel = i_insn[2:0];
        case (opcode)
            OP_BR: begin
                o_ctrl.is_branch = 1'b1;
                o_ctrl.nzp_mask  = i_insn[11:9];
                o_ctrl.imm       = {{7{i_insn[8]}}, i_insn[8:0]};
            end
            OP_ARITH, OP_LOGIC: begin
                // imm5 form, or register form with sub-op in insn[5:3]
                if (i_insn[5]) begin
                    o_ctrl.rs_re      = 1'b1;
                    o_ctrl.regfile_we = 1'b1;
                    o_ctrl.nzp_we     = 1'b1;
                    o_ctrl.use_imm    = 1'b1;
                    o_ctrl.imm        = {{11{i_insn[4]}}, i_insn[4:0]};
                    o_ctrl.alu_op     = (opcode == OP_ARITH) ? ALU_ADD : ALU_AND;
                end else if (i_insn[5:3] == 3'b000 ||
                             (opcode == OP_ARITH && i_insn[5:3] == 3'b010)) begin
                    o_ctrl.rs_re      = 1'b1;
                    o_ctrl.rt_re      = 1'b1;
                    o_ctrl.regfile_we = 1'b1;
                    o_ctrl.nzp_we     = 1'b1;
                    if (opcode == OP_LOGIC) begin
                        o_ctrl.alu_op = ALU_AND;
                    end else begin
                        o_ctrl.alu_op = (i_insn[5:3] == 3'b000) ? ALU_ADD : ALU_SUB;
                    end
                end
            end
            OP_LDR, OP_STR: begin
                // address is base plus imm6
                o_ctrl.rs_re      = 1'b1;
                o_ctrl.use_imm    = 1'b1;
                o_ctrl.imm        = {{10{i_insn[5]}}, i_insn[5:0]};
                o_ctrl.alu_op     = ALU_ADD;
                o_ctrl.is_load    = (opcode == OP_LDR);
                o_ctrl.is_store   = (opcode == OP_STR);
                o_ctrl.regfile_we = (opcode == OP_LDR);
                o_ctrl.nzp_we     = (opcode == OP_LDR);
                o_ctrl.rt_re      = (opcode == OP_STR);
                o_ctrl.rt_sel     = (opcode == OP_STR) ? i_insn[11:9] : i_insn[2:0];
            end
            OP_CONST: begin
                o_ctrl.regfile_we = 1'b1;
                o_ctrl.nzp_we     = 1'b1;
                o_ctrl.imm        = {{7{i_insn[8]}}, i_insn[8:0]};
                o_ctrl.alu_op     = ALU_PASS_IMM;
            end
            default: begin
                // unsupported encodings retire with no side effects
                o_ctrl.alu_op = ALU_NONE;
            end
        endcase
    end

endmodule

/* logic/lc4_execute.sv */
`timescale 1ns/1ps
`include "lc4_macros.svh"

module lc4_execute import lc4_pkg::*; (
    input  logic      gwe,
    input  logic      i_rst,
    input  lc4_word_t i_d_pc,
    input  lc4_word_t i_d_insn,
    input  logic      i_d_valid,
    input  lc4_word_t i_rs_data,
    input  lc4_word_t i_rt_data,
    lc4_fwd_if.dst    fwd,
    output logic      o_stall,
    output logic      o_flush,
    output lc4_word_t o_target,
    output lc4_ctrl_t o_x_ctrl,
    output lc4_word_t o_x_pc,
    output lc4_word_t o_x_insn,
    output logic      o_x_valid,
    output lc4_word_t o_x_result,
    output lc4_word_t o_x_store_data
);

    lc4_ctrl_t  d_ctrl;
    lc4_ctrl_t  x_ctrl_q;
    logic       x_valid_q;
    lc4_word_t  x_pc_q;
    lc4_word_t  x_insn_q;
    lc4_word_t  x_rs_q;
    lc4_word_t  x_rt_q;
    lc4_word_t  rs_val;
    lc4_word_t  rt_val;
    lc4_word_t  alu_b;
    lc4_word_t  alu_out;
    logic [2:0] nzp_q;
    logic [2:0] nzp_cur;
    logic       bubble;

    lc4_decoder u_dec (
        .i_insn (i_d_insn),
        .o_ctrl (d_ctrl)
    );

    // store data from a load is covered later by the WM path
    assign o_stall = i_d_valid && x_valid_q && x_ctrl_q.is_load &&
                     ((d_ctrl.rs_re && d_ctrl.rs_sel == x_ctrl_q.rd_sel) ||
                      (d_ctrl.rt_re && !d_ctrl.is_store && d_ctrl.rt_sel == x_ctrl_q.rd_sel));

    assign bubble = !i_d_valid || o_stall || o_flush;

    always_ff @(posedge gwe) begin
        if (i_rst || bubble) begin
            x_valid_q <= 1'b0;
            x_ctrl_q  <= '0;
            x_insn_q  <= `LC4_NOP_INSN;
        end else begin
            x_valid_q <= 1'b1;
            x_ctrl_q  <= d_ctrl;
            x_insn_q  <= i_d_insn;
        end
    end

    always_ff @(posedge gwe) begin
        x_pc_q <= i_d_pc;
        x_rs_q <= i_rs_data;
        x_rt_q <= i_rt_data;
    end

    // MX before WX before the register read
    assign rs_val = (fwd.m_we && fwd.m_sel == x_ctrl_q.rs_sel) ? fwd.m_data :
                    (fwd.w_we && fwd.w_sel == x_ctrl_q.rs_sel) ? fwd.w_data : x_rs_q;
    assign rt_val = (fwd.m_we && fwd.m_sel == x_ctrl_q.rt_sel) ? fwd.m_data :
                    (fwd.w_we && fwd.w_sel == x_ctrl_q.rt_sel) ? fwd.w_data : x_rt_q;

    assign alu_b = x_ctrl_q.use_imm ? x_ctrl_q.imm : rt_val;

    always_comb begin
        case (x_ctrl_q.alu_op)
            ALU_ADD:      alu_out = rs_val + alu_b;
            ALU_SUB:      alu_out = rs_val - alu_b;
            ALU_AND:      alu_out = rs_val & alu_b;
            ALU_PASS_IMM: alu_out = x_ctrl_q.imm;
            default:      alu_out = '0;
        endcase
    end

    // architectural NZP updated as instructions leave writeback
    always_ff @(posedge gwe) begin
        if (i_rst) begin
            nzp_q <= '0;
        end else if (fwd.w_nzp_we) begin
            nzp_q <= fwd.w_nzp;
        end
    end

    assign nzp_cur = fwd.m_nzp_we ? fwd.m_nzp :
                     fwd.w_nzp_we ? fwd.w_nzp : nzp_q;

    assign o_flush  = x_valid_q && x_ctrl_q.is_branch && |(x_ctrl_q.nzp_mask & nzp_cur);
    assign o_target = x_pc_q + lc4_word_t'(1) + x_ctrl_q.imm;

    assign o_x_ctrl       = x_ctrl_q;
    assign o_x_pc         = x_pc_q;
    assign o_x_insn       = x_insn_q;
    assign o_x_valid      = x_valid_q;
    assign o_x_result     = alu_out;
    assign o_x_store_data = rt_val;

    // the instruction fetched behind a taken branch never reaches decode
    a_flush_from_branch: assert property (@(posedge gwe) disable iff (i_rst)
        o_flush |=> !i_d_valid);

endmodule

/* logic/lc4_fetch.sv */
`timescale 1ns/1ps
`include "lc4_macros.svh"

module lc4_fetch import lc4_pkg::*; (
    input  logic      gwe,
    input  logic      i_rst,
    input  logic      i_stall,
    input  logic      i_flush,
    input  lc4_word_t i_target,
    output lc4_word_t o_imem_addr,
    input  lc4_word_t i_imem_insn,
    output lc4_word_t o_d_pc,
    output lc4_word_t o_d_insn,
    output logic      o_d_valid
);

    lc4_word_t pc_q;

    assign o_imem_addr = pc_q;

    always_ff @(posedge gwe) begin
        if (i_rst) begin
            pc_q      <= `LC4_RESET_PC;
            o_d_insn  <= `LC4_NOP_INSN;
            o_d_valid <= 1'b0;
        end else if (i_flush) begin
            // redirect and kill whatever was fetched this cycle
            pc_q      <= i_target;
            o_d_insn  <= `LC4_NOP_INSN;
            o_d_valid <= 1'b0;
        end else if (!i_stall) begin
            pc_q      <= pc_q + lc4_word_t'(1);
            o_d_insn  <= i_imem_insn;
            o_d_valid <= 1'b1;
        end
    end

    // pc of the decode instruction, only meaningful with o_d_valid
    always_ff @(posedge gwe) begin
        if (!i_stall) begin
            o_d_pc <= pc_q;
        end
    end

    // load-use and branch hazards come from different instructions
    a_no_stall_and_flush: assert property (@(posedge gwe) disable iff (i_rst)
        !(i_stall && i_flush));

endmodule

/* logic/lc4_fwd_if.sv */
`timescale 1ns/1ps
`include "lc4_macros.svh"

// results travelling back from memory and writeback into execute
interface lc4_fwd_if;
    logic                 m_we;
    logic [2:0]           m_sel;
    logic [`LC4_XLEN-1:0] m_data;
    logic                 m_nzp_we;
    logic [2:0]           m_nzp;
    logic                 w_we;
    logic [2:0]           w_sel;
    logic [`LC4_XLEN-1:0] w_data;
    logic                 w_nzp_we;
    logic [2:0]           w_nzp;

    modport src (
        output m_we, m_sel, m_data, m_nzp_we, m_nzp,
        output w_we, w_sel, w_data, w_nzp_we, w_nzp
    );

    modport dst (
        input m_we, m_sel, m_data, m_nzp_we, m_nzp,
        input w_we, w_sel, w_data, w_nzp_we, w_nzp
    );
endinterface

/* logic/lc4_memwb.sv */
`timescale 1ns/1ps
`include "lc4_macros.svh"

module lc4_memwb import lc4_pkg::*; (
    input  logic       gwe,
    input  logic       i_rst,
    input  lc4_ctrl_t  i_x_ctrl,
    input  lc4_word_t  i_x_pc,
    input  lc4_word_t  i_x_insn,
    input  logic       i_x_valid,
    input  lc4_word_t  i_x_result,
    input  lc4_word_t  i_x_store_data,
    output lc4_word_t  o_dmem_addr,
    output logic       o_dmem_we,
    output lc4_word_t  o_dmem_wdata,
    input  lc4_word_t  i_dmem_rdata,
    lc4_fwd_if.src     fwd,
    output logic       o_trace_valid,
    output lc4_word_t  o_trace_pc,
    output lc4_word_t  o_trace_insn,
    output logic       o_regfile_we,
    output lc4_rsel_t  o_regfile_wsel,
    output lc4_word_t  o_regfile_wdata,
    output logic       o_nzp_we,
    output logic [2:0] o_nzp_bits
);

    lc4_ctrl_t  m_ctrl;
    logic       m_valid;
    lc4_word_t  m_pc;
    lc4_word_t  m_insn;
    lc4_word_t  m_result;
    lc4_word_t  m_store_data;
    lc4_word_t  m_value;
    logic [2:0] m_nzp_bits;

    always_ff @(posedge gwe) begin
        if (i_rst) begin
            m_valid <= 1'b0;
            m_ctrl  <= '0;
        end else begin
            m_valid <= i_x_valid;
            m_ctrl  <= i_x_ctrl;
        end
    end

    always_ff @(posedge gwe) begin
        m_pc         <= i_x_pc;
        m_insn       <= i_x_insn;
        m_result     <= i_x_result;
        m_store_data <= i_x_store_data;
    end

    assign o_dmem_addr = m_result;
    assign o_dmem_we   = m_valid && m_ctrl.is_store;

    // WM bypass for store data
    assign o_dmem_wdata = (o_regfile_we && o_regfile_wsel == m_ctrl.rt_sel) ?
                          o_regfile_wdata : m_store_data;

    assign m_value    = m_ctrl.is_load ? i_dmem_rdata : m_result;
    assign m_nzp_bits = {m_value[`LC4_XLEN-1],
                         m_value == '0,
                         !m_value[`LC4_XLEN-1] && m_value != '0};

    always_ff @(posedge gwe) begin
        if (i_rst) begin
            o_trace_valid  <= 1'b0;
            o_regfile_we   <= 1'b0;
            o_regfile_wsel <= '0;
            o_nzp_we       <= 1'b0;
        end else begin
            o_trace_valid  <= m_valid;
            o_regfile_we   <= m_ctrl.regfile_we;
            o_regfile_wsel <= m_ctrl.rd_sel;
            o_nzp_we       <= m_ctrl.nzp_we;
        end
    end

    always_ff @(posedge gwe) begin
        o_trace_pc      <= m_pc;
        o_trace_insn    <= m_insn;
        o_regfile_wdata <= m_value;
        o_nzp_bits      <= m_nzp_bits;
    end

    // load data is not ready for MX, the stall covers that case
    assign fwd.m_we     = m_ctrl.regfile_we && !m_ctrl.is_load;
    assign fwd.m_sel    = m_ctrl.rd_sel;
    assign fwd.m_data   = m_result;
    assign fwd.m_nzp_we = m_ctrl.nzp_we;
    assign fwd.m_nzp    = m_nzp_bits;
    assign fwd.w_we     = o_regfile_we;
    assign fwd.w_sel    = o_regfile_wsel;
    assign fwd.w_data   = o_regfile_wdata;
    assign fwd.w_nzp_we = o_nzp_we;
    assign fwd.w_nzp    = o_nzp_bits;

    // decode never marks one instruction as both load and store
    a_store_not_load: assert property (@(posedge gwe) disable iff (i_rst)
        !(o_dmem_we && m_ctrl.is_load));

endmodule

/* logic/lc4_pkg.sv */
`include "lc4_macros.svh"

package lc4_pkg;

    typedef logic [`LC4_XLEN-1:0] lc4_word_t;
    typedef logic [2:0] lc4_rsel_t;

    // values match insn[15:12]
    typedef enum logic [3:0] {
        OP_BR    = 4'h0,
        OP_ARITH = 4'h1,
        OP_LOGIC = 4'h5,
        OP_LDR   = 4'h6,
        OP_STR   = 4'h7,
        OP_CONST = 4'h9,
        OP_OTHER = 4'hf
    } lc4_opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_PASS_IMM,
        ALU_NONE
    } lc4_alu_op_e;

    typedef struct packed {
        lc4_rsel_t   rs_sel;
        lc4_rsel_t   rt_sel;
        lc4_rsel_t   rd_sel;
        logic        rs_re;
        logic        rt_re;
        logic        regfile_we;
        logic        nzp_we;
        logic        is_load;
        logic        is_store;
        logic        is_branch;
        logic [2:0]  nzp_mask;
        lc4_alu_op_e alu_op;
        logic        use_imm;
        lc4_word_t   imm;
    } lc4_ctrl_t;

endpackage

/* logic/lc4_regfile.sv */
`timescale 1ns/1ps
`include "lc4_macros.svh"

module lc4_regfile import lc4_pkg::*; (
    input  logic      gwe,
    input  logic      i_rst,
    input  lc4_rsel_t i_rs_sel,
    input  lc4_rsel_t i_rt_sel,
    output lc4_word_t o_rs_data,
    output lc4_word_t o_rt_data,
    input  logic      i_we,
    input  lc4_rsel_t i_wsel,
    input  lc4_word_t i_wdata
);

    lc4_word_t regs [`LC4_NREGS];

    always_ff @(posedge gwe) begin
        if (i_rst) begin
            for (int i = 0; i < `LC4_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we) begin
            regs[i_wsel] <= i_wdata;
        end
    end

    // writeback result is visible to decode in the same cycle
    assign o_rs_data = (i_we && i_wsel == i_rs_sel) ? i_wdata : regs[i_rs_sel];
    assign o_rt_data = (i_we && i_wsel == i_rt_sel) ? i_wdata : regs[i_rt_sel];

endmodule

/* run.sh */
#!/usr/bin/env bash
# build and run the LC4 pipeline testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module lc4_tb \
    --Mdir obj_dir \
    -o lc4_sim \
    -f verilog.f
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit $build_status
fi

./obj_dir/lc4_sim
sim_status=$?
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit $sim_status
fi
exit 0

/* verilog.f */
+incdir+include
logic/lc4_pkg.sv
logic/lc4_fwd_if.sv
logic/lc4_decoder.sv
logic/lc4_fetch.sv
logic/lc4_regfile.sv
logic/lc4_execute.sv
logic/lc4_memwb.sv
logic/lc4_core.sv
dv/lc4_tb.sv
